/* cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// geometry shared by both caches
`define CACHE_LINES  1024
`define INDEX_BITS   10
`define TAG_BITS     20

// words fetched by one instruction refill burst
`define REFILL_BEATS 8

// ARBURST codes
`define BURST_FIXED  2'b00
`define BURST_INCR   2'b01

`endif

/* cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

  // address split as seen by a direct-mapped, one-word-line cache
  typedef struct packed {
    logic [`TAG_BITS-1:0]   tag;
    logic [`INDEX_BITS-1:0] index;
    logic [1:0]             byteOffset;
  } addrFields_t;

  // same 32 bits, either raw or decoded
  typedef union packed {
    logic [31:0] word;
    addrFields_t f;
  } cacheAddr_u;

  // one line of either cache array
  typedef struct packed {
    logic                 valid;
    logic [`TAG_BITS-1:0] tag;
    logic [31:0]          data;
  } cacheLine_t;

endpackage

/* memRead_if.sv */
`timescale 1ns/1ns

interface memRead_if;

  // requester side
  logic        req;
  logic [31:0] addr;

  // engine side, one beatValid pulse per returned word
  logic        beatValid;
  logic [31:0] beatData;
  logic        last;

  // req held with stable addr until the last beat
  modport requester (
    output req, addr,
    input  beatValid, beatData, last
  );

  modport engine (
    input  req, addr,
    output beatValid, beatData, last
  );

endinterface

/* memWrite_if.sv */
`timescale 1ns/1ns

interface memWrite_if;

  // one write, fields held stable while req is high
  logic        req;
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;

  // single-cycle pulse once B has completed
  logic        done;

  modport requester (
    output req, addr, data, strb,
    input  done
  );

  modport engine (
    input  req, addr, data, strb,
    output done
  );

endinterface

/* instCache.sv */
`timescale 1ns/1ns
`include "cache_defs.svh"

module instCache import cache_pkg::*; (
  input  logic         clk,
  input  logic         resetn,
  input  logic         req,
  input  logic [31:0]  addr,
  output logic         addrOk,
  output logic         dataOk,
  output logic [31:0]  rdata,
  memRead_if.requester rd
);

  localparam int beatBits = $clog2(`REFILL_BEATS);

  typedef enum logic [1:0] {stIdle, stLookup, stRefill, stResp} state_t;

  state_t                 state;
  cacheAddr_u             reqAddr;
  cacheAddr_u             blockAddr;
  logic [beatBits-1:0]    beatCnt;
  logic [`INDEX_BITS-1:0] fillIndex;
  cacheLine_t             lines [`CACHE_LINES];
  cacheLine_t             lineRd;
  logic                   hit;

  // tag compare on the registered address
  assign lineRd = lines[reqAddr.f.index];
  assign hit    = lineRd.valid && (lineRd.tag == reqAddr.f.tag);

  // aligned block base for the burst
  always_comb begin
    blockAddr = reqAddr;
    blockAddr.f.index[beatBits-1:0] = '0;
    blockAddr.f.byteOffset = 2'b00;
  end

  // beat n lands in line base+n
  assign fillIndex = {reqAddr.f.index[`INDEX_BITS-1:beatBits], beatCnt};

  assign addrOk  = (state == stIdle);
  assign rd.req  = (state == stRefill);
  assign rd.addr = blockAddr.word;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= stIdle;
      dataOk  <= 1'b0;
      beatCnt <= '0;
    end else begin
      dataOk <= 1'b0;
      case (state)
        stIdle: begin
          if (req) begin
            state <= stLookup;
          end
        end
        stLookup: begin
          if (hit) begin
            dataOk <= 1'b1;
            state  <= stResp;
          end else begin
            beatCnt <= '0;
            state   <= stRefill;
          end
        end
        stRefill: begin
          if (rd.beatValid) begin
            beatCnt <= beatCnt + 1'b1;
            // look up again, the line is now filled
            if (rd.last) begin
              state <= stLookup;
            end
          end
        end
        stResp:  state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req && addrOk) begin
      reqAddr.word <= addr;
    end
    if (state == stLookup) begin
      rdata <= lineRd.data;
    end
  end

  // line array, only the valid bits are cleared
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `CACHE_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else if (state == stRefill && rd.beatValid) begin
      lines[fillIndex] <= '{valid: 1'b1, tag: reqAddr.f.tag, data: rd.beatData};
    end
  end

endmodule

/* dataCache.sv */
`timescale 1ns/1ns
`include "cache_defs.svh"

module dataCache import cache_pkg::*; (
  input  logic         clk,
  input  logic         resetn,
  input  logic         req,
  input  logic         wr,
  input  logic [3:0]   wstrb,
  input  logic [31:0]  addr,
  input  logic [31:0]  wdata,
  output logic         addrOk,
  output logic         dataOk,
  output logic [31:0]  rdata,
  memRead_if.requester rd,
  memWrite_if.requester wrPort
);

  typedef enum logic [2:0] {
    stIdle,
    stLookup,
    stRefill,
    stWrite,
    stResp
  } state_t;

  state_t      state;
  cacheAddr_u  reqAddr;
  logic        reqWr;
  logic [3:0]  reqStrb;
  logic [31:0] reqData;
  cacheLine_t  lines [`CACHE_LINES];
  cacheLine_t  lineRd;
  logic        hit;
  logic [31:0] mergedData;

  assign lineRd = lines[reqAddr.f.index];
  assign hit    = lineRd.valid && (lineRd.tag == reqAddr.f.tag);

  // strobed bytes over the cached word
  always_comb begin
    mergedData = lineRd.data;
    for (int b = 0; b < 4; b++) begin
      if (reqStrb[b]) begin
        mergedData[8*b +: 8] = reqData[8*b +: 8];
      end
    end
  end

  assign addrOk = (state == stIdle);

  ////////////////////////////////////////////////////////////////////////////
  // bus requests
  ////////////////////////////////////////////////////////////////////////////

  // single word refill at the exact address
  assign rd.req  = (state == stRefill);
  assign rd.addr = reqAddr.word;

  // write-through, original request goes out unchanged
  assign wrPort.req  = (state == stWrite);
  assign wrPort.addr = reqAddr.word;
  assign wrPort.data = reqData;
  assign wrPort.strb = reqStrb;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state  <= stIdle;
      dataOk <= 1'b0;
    end else begin
      dataOk <= 1'b0;
      case (state)
        stIdle: begin
          if (req) begin
            state <= stLookup;
          end
        end
        stLookup: begin
          if (reqWr) begin
            state <= stWrite;
          end else if (hit) begin
            dataOk <= 1'b1;
            state  <= stResp;
          end else begin
            state <= stRefill;
          end
        end
        stRefill: begin
          if (rd.beatValid && rd.last) begin
            state <= stLookup;
          end
        end
        stWrite: begin
          // cpu write ends with the B response
          if (wrPort.done) begin
            dataOk <= 1'b1;
            state  <= stResp;
          end
        end
        stResp:  state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req && addrOk) begin
      reqAddr.word <= addr;
      reqWr        <= wr;
      reqStrb      <= wstrb;
      reqData      <= wdata;
    end
    if (state == stLookup) begin
      rdata <= lineRd.data;
    end
  end

  // no allocate on write miss, hit lines take the merge
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `CACHE_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else if (state == stLookup && reqWr && hit) begin
      lines[reqAddr.f.index].data <= mergedData;
    end else if (state == stRefill && rd.beatValid) begin
      lines[reqAddr.f.index] <= '{valid: 1'b1, tag: reqAddr.f.tag, data: rd.beatData};
    end
  end

endmodule

/* axiReadEngine.sv */
`timescale 1ns/1ns
`include "cache_defs.svh"

module axiReadEngine import cache_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  memRead_if.engine   instRd,
  memRead_if.engine   dataRd,
  output logic [31:0] arAddr,
  output logic [7:0]  arLen,
  output logic [1:0]  arBurst,
  output logic        arValid,
  input  logic        arReady,
  input  logic [31:0] rData,
  input  logic        rLast,
  input  logic        rValid,
  output logic        rReady
);

  typedef enum logic [1:0] {stIdle, stAddr, stData, stDrain} state_t;

  state_t state;
  logic   grantData;

  assign arValid = (state == stAddr);
  assign rReady  = (state == stData);

  // R beats steered to whichever side won
  assign dataRd.beatValid = rReady && rValid && grantData;
  assign instRd.beatValid = rReady && rValid && !grantData;
  assign dataRd.beatData  = rData;
  assign instRd.beatData  = rData;
  assign dataRd.last      = rLast;
  assign instRd.last      = rLast;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= stIdle;
      grantData <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          // data side first
          if (dataRd.req) begin
            grantData <= 1'b1;
            state     <= stAddr;
          end else if (instRd.req) begin
            grantData <= 1'b0;
            state     <= stAddr;
          end
        end
        stAddr: begin
          if (arReady) begin
            state <= stData;
          end
        end
        stData: begin
          if (rValid && rLast) begin
            state <= stDrain;
          end
        end
        // requester drops req here
        stDrain: state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stIdle) begin
      if (dataRd.req) begin
        arAddr  <= dataRd.addr;
        arLen   <= 8'd0;
        arBurst <= `BURST_FIXED;
      end else if (instRd.req) begin
        arAddr  <= instRd.addr;
        arLen   <= 8'(`REFILL_BEATS - 1);
        arBurst <= `BURST_INCR;
      end
    end
  end

endmodule

/* axiWriteEngine.sv */
`timescale 1ns/1ns

module axiWriteEngine import cache_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  memWrite_if.engine  wrPort,
  output logic [31:0] awAddr,
  output logic        awValid,
  input  logic        awReady,
  output logic [31:0] wData,
  output logic [3:0]  wStrb,
  output logic        wValid,
  input  logic        wReady,
  input  logic        bValid,
  output logic        bReady
);

  typedef enum logic [1:0] {stIdle, stAddr, stData, stResp} state_t;

  state_t state;
  logic   donePulse;
  logic   start;

  // req is still high while done is out, so skip that cycle
  assign start = (state == stIdle) && wrPort.req && !donePulse;

  assign awValid     = (state == stAddr);
  assign wValid      = (state == stData);
  assign bReady      = (state == stResp);
  assign wrPort.done = donePulse;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= stIdle;
      donePulse <= 1'b0;
    end else begin
      donePulse <= 1'b0;
      case (state)
        stIdle: if (start) state <= stAddr;
        stAddr: if (awReady) state <= stData;
        stData: if (wReady) state <= stResp;
        stResp: begin
          if (bValid) begin
            donePulse <= 1'b1;
            state     <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      awAddr <= wrPort.addr;
      wData  <= wrPort.data;
      wStrb  <= wrPort.strb;
    end
  end

endmodule

/* cacheTop.sv */
`timescale 1ns/1ns

module cacheTop import cache_pkg::*; (
  input  logic        clk,
  input  logic        resetn,

  // instruction port
  input  logic        instReq,
  input  logic [31:0] instAddr,
  output logic        instAddrOk,
  output logic        instDataOk,
  output logic [31:0] instRdata,

  // data port
  input  logic        dataReq,
  input  logic        dataWr,
  input  logic [3:0]  dataWstrb,
  input  logic [31:0] dataAddr,
  input  logic [31:0] dataWdata,
  output logic        dataAddrOk,
  output logic        dataDataOk,
  output logic [31:0] dataRdata,

  // read channels
  output logic [31:0] arAddr,
  output logic [7:0]  arLen,
  output logic [1:0]  arBurst,
  output logic        arValid,
  input  logic        arReady,
  input  logic [31:0] rData,
  input  logic        rLast,
  input  logic        rValid,
  output logic        rReady,

  // write channels
  output logic [31:0] awAddr,
  output logic        awValid,
  input  logic        awReady,
  output logic [31:0] wData,
  output logic [3:0]  wStrb,
  output logic        wValid,
  input  logic        wReady,
  input  logic        bValid,
  output logic        bReady
);

  memRead_if  instRd ();
  memRead_if  dataRd ();
  memWrite_if dataWrIf ();

  ////////////////////////////////////////////////////////////////////////////
  // caches
  ////////////////////////////////////////////////////////////////////////////

  instCache instCache_i (
    .clk    (clk),
    .resetn (resetn),
    .req    (instReq),
    .addr   (instAddr),
    .addrOk (instAddrOk),
    .dataOk (instDataOk),
    .rdata  (instRdata),
    .rd     (instRd.requester)
  );

  dataCache dataCache_i (
    .clk    (clk),
    .resetn (resetn),
    .req    (dataReq),
    .wr     (dataWr),
    .wstrb  (dataWstrb),
    .addr   (dataAddr),
    .wdata  (dataWdata),
    .addrOk (dataAddrOk),
    .dataOk (dataDataOk),
    .rdata  (dataRdata),
    .rd     (dataRd.requester),
    .wrPort (dataWrIf.requester)
  );

  ////////////////////////////////////////////////////////////////////////////
  // bus engines
  ////////////////////////////////////////////////////////////////////////////

  axiReadEngine axiReadEngine_i (
    .clk     (clk),
    .resetn  (resetn),
    .instRd  (instRd.engine),
    .dataRd  (dataRd.engine),
    .arAddr  (arAddr),
    .arLen   (arLen),
    .arBurst (arBurst),
    .arValid (arValid),
    .arReady (arReady),
    .rData   (rData),
    .rLast   (rLast),
    .rValid  (rValid),
    .rReady  (rReady)
  );

  axiWriteEngine axiWriteEngine_i (
    .clk     (clk),
    .resetn  (resetn),
    .wrPort  (dataWrIf.engine),
    .awAddr  (awAddr),
    .awValid (awValid),
    .awReady (awReady),
    .wData   (wData),
    .wStrb   (wStrb),
    .wValid  (wValid),
    .wReady  (wReady),
    .bValid  (bValid),
    .bReady  (bReady)
  );

endmodule

/* cacheChecker.sv */
`timescale 1ns/1ns
`include "cache_defs.svh"

module cacheChecker import cache_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic        instReq,
  input  logic [31:0] instAddr,
  input  logic        instAddrOk,
  input  logic        instDataOk,
  input  logic [31:0] instRdata,
  input  logic        dataReq,
  input  logic        dataWr,
  input  logic [3:0]  dataWstrb,
  input  logic [31:0] dataAddr,
  input  logic [31:0] dataWdata,
  input  logic        dataAddrOk,
  input  logic        dataDataOk,
  input  logic [31:0] dataRdata,
  input  logic [31:0] arAddr,
  input  logic [7:0]  arLen,
  input  logic [1:0]  arBurst,
  input  logic        arValid,
  input  logic        arReady,
  input  logic        rReady,
  input  logic [31:0] awAddr,
  input  logic        awValid,
  input  logic        awReady,
  input  logic [31:0] wData,
  input  logic [3:0]  wStrb,
  input  logic        wValid,
  input  logic        wReady,
  input  logic        bReady,
  output int          checkCount,
  output int          mismatchCount,
  output int          failCount
);

  localparam logic sideInst = 1'b0;
  localparam logic sideData = 1'b1;

  // tag model of both arrays
  logic [`CACHE_LINES-1:0] validModel [2];
  logic [`TAG_BITS-1:0]    tagModel [2][`CACHE_LINES];

  // memory contents as the CPU has written them
  logic [31:0] shadow [logic [29:0]];

  // one request in flight per side
  logic        busy [2];
  cacheAddr_u  pendAddr [2];
  logic        pendHit [2];
  logic        arSeen [2];
  int          accCycle [2];
  logic [31:0] expWord [2];
  logic        pendWr;
  logic [3:0]  pendStrb;
  logic [31:0] pendData;
  logic        wSeen;
  int          cycle;
  logic        resetChecked;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] memWord(input logic [31:0] a);
    return (a ^ 32'hA5A5_0000) + (a >> 2);
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] d,
                                             input logic [3:0] s);
    logic [31:0] w;
    w = old;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        w[8*i +: 8] = d[8*i +: 8];
      end
    end
    return w;
  endfunction

  // expected word seen by a read of address a
  function automatic logic [31:0] refWord(input logic [31:0] a);
    if (shadow.exists(a[31:2])) begin
      return shadow[a[31:2]];
    end
    return memWord(a);
  endfunction

  function automatic logic wantsAr(input logic s);
    return busy[s] && !pendHit[s] && !arSeen[s] && !(s == sideData && pendWr);
  endfunction

  task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      mismatchCount++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic failure(input string msg);
    failCount++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic checkReset();
    checkCount++;
    if (!instAddrOk || !dataAddrOk || instDataOk || dataDataOk || arValid || awValid ||
        wValid || rReady || bReady) begin
      mismatchCount++;
      $display("Mismatch at %0t ns: control outputs not at their reset values", $time);
    end
    resetChecked = 1'b1;
  endtask

  task automatic accept(input logic s, input logic [31:0] a);
    cacheAddr_u ca;
    ca.word     = a;
    busy[s]     = 1'b1;
    pendAddr[s] = ca;
    accCycle[s] = cycle;
    arSeen[s]   = 1'b0;
    pendHit[s]  = validModel[s][ca.f.index] && (tagModel[s][ca.f.index] == ca.f.tag);
    expWord[s]  = refWord(a);
  endtask

  task automatic complete(input logic s, input logic [31:0] rdata);
    if (!busy[s]) begin
      failure("dataOk arrived with no request outstanding");
    end else if (s == sideData && pendWr) begin
      if (!wSeen) failure("write completed before its W transfer");
    end else begin
      expectEq(s ? "data rdata" : "inst rdata", rdata, expWord[s]);
      if (pendHit[s]) expectEq("hit latency in cycles", cycle - accCycle[s], 32'd2);
      else if (!arSeen[s]) failure("miss completed without a bus read");
    end
    busy[s] = 1'b0;
  endtask

  // data side wins when it asked no later than the instruction side
  task automatic checkAr();
    cacheAddr_u ca;
    cacheAddr_u blk;
    logic [`INDEX_BITS-1:0] idx;
    if (wantsAr(sideData) &&
        (!wantsAr(sideInst) || accCycle[sideData] <= accCycle[sideInst])) begin
      arSeen[sideData] = 1'b1;
      ca = pendAddr[sideData];
      expectEq("data arAddr", arAddr, ca.word);
      expectEq("data arLen", 32'(arLen), 32'd0);
      expectEq("data arBurst", 32'(arBurst), 32'(`BURST_FIXED));
      validModel[sideData][ca.f.index] = 1'b1;
      tagModel[sideData][ca.f.index] = ca.f.tag;
    end else if (wantsAr(sideInst)) begin
      arSeen[sideInst] = 1'b1;
      ca = pendAddr[sideInst];
      blk.word = ca.word & ~32'(`REFILL_BEATS * 4 - 1);
      expectEq("inst arAddr", arAddr, blk.word);
      expectEq("inst arLen", 32'(arLen), 32'(`REFILL_BEATS - 1));
      expectEq("inst arBurst", 32'(arBurst), 32'(`BURST_INCR));
      idx = blk.f.index;
      for (int i = 0; i < `REFILL_BEATS; i++) begin
        validModel[sideInst][idx] = 1'b1;
        tagModel[sideInst][idx] = ca.f.tag;
        idx = idx + 1'b1;
      end
    end else begin
      failure("AR issued with no read miss outstanding");
    end
  endtask

  task automatic checkAw();
    if (!(busy[sideData] && pendWr)) failure("AW issued with no write outstanding");
    else expectEq("awAddr", awAddr, pendAddr[sideData].word);
  endtask

  task automatic checkW();
    if (!(busy[sideData] && pendWr)) begin
      failure("W issued with no write outstanding");
    end else begin
      expectEq("wData", wData, pendData);
      expectEq("wStrb", 32'(wStrb), 32'(pendStrb));
      wSeen = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // port monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!resetn) begin
      validModel[0] = '0;
      validModel[1] = '0;
      busy[0]       = 1'b0;
      busy[1]       = 1'b0;
      cycle         = 0;
      resetChecked  = 1'b0;
      checkCount    = 0;
      mismatchCount = 0;
      failCount     = 0;
    end else begin
      cycle = cycle + 1;
      if (!resetChecked) checkReset();
      if (instDataOk) complete(sideInst, instRdata);
      if (dataDataOk) complete(sideData, dataRdata);
      if (arValid && arReady) checkAr();
      if (awValid && awReady) checkAw();
      if (wValid && wReady) checkW();
      if (instReq && instAddrOk) accept(sideInst, instAddr);
      if (dataReq && dataAddrOk) begin
        accept(sideData, dataAddr);
        pendWr   = dataWr;
        pendStrb = dataWstrb;
        pendData = dataWdata;
        wSeen    = 1'b0;
        // write-through, memory takes the bytes whether or not the line hits
        if (dataWr) shadow[dataAddr[31:2]] = mergeBytes(refWord(dataAddr), dataWdata, dataWstrb);
      end
    end
  end

endmodule

/* tb_cacheTop.sv */
`timescale 1ns/1ns
`include "cache_defs.svh"

module tb_cacheTop;

  localparam int clkPeriod       = 40;
  localparam int resetCycles     = 10;
  // 36 fetches, 8 reads, 20 write tests, 12 conflicts, 6 arbitration
  localparam int plannedRequests = 82;

  logic        clk;
  logic        resetn;
  logic        instReq;
  logic [31:0] instAddr;
  logic        instAddrOk;
  logic        instDataOk;
  logic [31:0] instRdata;
  logic        dataReq;
  logic        dataWr;
  logic [3:0]  dataWstrb;
  logic [31:0] dataAddr;
  logic [31:0] dataWdata;
  logic        dataAddrOk;
  logic        dataDataOk;
  logic [31:0] dataRdata;
  logic [31:0] arAddr;
  logic [7:0]  arLen;
  logic [1:0]  arBurst;
  logic        arValid;
  logic        arReady;
  logic [31:0] rData;
  logic        rLast;
  logic        rValid;
  logic        rReady;
  logic [31:0] awAddr;
  logic        awValid;
  logic        awReady;
  logic [31:0] wData;
  logic [3:0]  wStrb;
  logic        wValid;
  logic        wReady;
  logic        bValid;
  logic        bReady;
  int          checkCount;
  int          mismatchCount;
  int          failCount;

  int          seed;
  logic [31:0] busMem [logic [29:0]];

  cacheTop cacheTop_i (.*);

  cacheChecker checker_i (.*);

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] memWord(input logic [31:0] a);
    return (a ^ 32'hA5A5_0000) + (a >> 2);
  endfunction

  function automatic logic [31:0] busWord(input logic [31:0] a);
    if (busMem.exists(a[31:2])) begin
      return busMem[a[31:2]];
    end
    return memWord(a);
  endfunction

  function automatic int readyDelay();
    return $unsigned($random(seed)) % 4;
  endfunction

  // data lives below 0x1000_0000, code at 0x8000_0000 and up
  function automatic logic [31:0] dataRand();
    return $random(seed) & 32'h0FFF_FFFC;
  endfunction

  function automatic logic [31:0] instBlock();
    return 32'h8000_0000 | ($random(seed) & 32'h0FFF_FFE0);
  endfunction

  task automatic storeWrite(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] w;
    w = busWord(a);
    for (int i = 0; i < 4; i++) begin
      if (s[i]) w[8*i +: 8] = d[8*i +: 8];
    end
    busMem[a[31:2]] = w;
  endtask

  task automatic fetch(input logic [31:0] a);
    @(negedge clk);
    instReq  = 1'b1;
    instAddr = a;
    do @(posedge clk); while (!instAddrOk);
    @(negedge clk);
    instReq = 1'b0;
    do @(posedge clk); while (!instDataOk);
  endtask

  task automatic access(input logic w, input logic [31:0] a, input logic [3:0] s,
                        input logic [31:0] d);
    @(negedge clk);
    dataReq   = 1'b1;
    dataWr    = w;
    dataAddr  = a;
    dataWstrb = s;
    dataWdata = d;
    do @(posedge clk); while (!dataAddrOk);
    @(negedge clk);
    dataReq = 1'b0;
    do @(posedge clk); while (!dataDataOk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rdAddr;
    int          beats;
    forever begin
      @(negedge clk);
      if (arValid) begin
        repeat (readyDelay()) @(negedge clk);
        arReady = 1'b1;
        rdAddr  = arAddr;
        beats   = int'(arLen) + 1;
        @(negedge clk);
        arReady = 1'b0;
        for (int i = 0; i < beats; i++) begin
          repeat (readyDelay()) @(negedge clk);
          rValid = 1'b1;
          rData  = busWord(rdAddr + 4 * i);
          rLast  = (i == beats - 1);
          do @(posedge clk); while (!rReady);
          @(negedge clk);
          rValid = 1'b0;
          rLast  = 1'b0;
        end
      end
    end
  end

  initial begin
    logic [31:0] wrAddr;
    forever begin
      @(negedge clk);
      if (awValid) begin
        repeat (readyDelay()) @(negedge clk);
        awReady = 1'b1;
        wrAddr  = awAddr;
        @(negedge clk);
        awReady = 1'b0;
        while (!wValid) @(negedge clk);
        repeat (readyDelay()) @(negedge clk);
        wReady = 1'b1;
        storeWrite(wrAddr, wData, wStrb);
        @(negedge clk);
        wReady = 1'b0;
        repeat (readyDelay()) @(negedge clk);
        bValid = 1'b1;
        do @(posedge clk); while (!bReady);
        @(negedge clk);
        bValid = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] base;
    logic [31:0] a;
    logic [31:0] b;
    seed      = 32'h96d4dd1e;
    resetn    = 1'b0;
    instReq   = 1'b0;
    instAddr  = '0;
    dataReq   = 1'b0;
    dataWr    = 1'b0;
    dataWstrb = '0;
    dataAddr  = '0;
    dataWdata = '0;
    arReady   = 1'b0;
    rData     = '0;
    rLast     = 1'b0;
    rValid    = 1'b0;
    awReady   = 1'b0;
    wReady    = 1'b0;
    bValid    = 1'b0;
    repeat (resetCycles) @(negedge clk);
    resetn = 1'b1;

    // miss in the middle of a block, then every word of it
    for (int n = 0; n < 4; n++) begin
      base = instBlock();
      fetch(base + 12);
      for (int i = 0; i < `REFILL_BEATS; i++) begin
        fetch(base + 4 * i);
      end
    end

    for (int n = 0; n < 4; n++) begin
      a = dataRand();
      access(1'b0, a, 4'h0, 32'h0);
      access(1'b0, a, 4'h0, 32'h0);
    end

    // write hit, then write miss followed by a read
    for (int n = 0; n < 4; n++) begin
      a = dataRand();
      access(1'b0, a, 4'h0, 32'h0);
      access(1'b1, a, 4'($random(seed)), $random(seed));
      access(1'b0, a, 4'h0, 32'h0);
      b = dataRand();
      access(1'b1, b, 4'($random(seed)), $random(seed));
      access(1'b0, b, 4'h0, 32'h0);
    end

    // same index, other tag
    for (int n = 0; n < 3; n++) begin
      a = dataRand();
      b = a ^ 32'h0010_0000;
      access(1'b0, a, 4'h0, 32'h0);
      access(1'b0, b, 4'h0, 32'h0);
      access(1'b0, a, 4'h0, 32'h0);
      access(1'b0, b, 4'h0, 32'h0);
    end

    for (int n = 0; n < 3; n++) begin
      base = instBlock();
      a    = dataRand();
      fork
        fetch(base);
        access(1'b0, a, 4'h0, 32'h0);
      join
    end

    repeat (4) @(negedge clk);
    $display("checks %0d, mismatches %0d, other errors %0d",
             checkCount, mismatchCount, failCount);
    if (mismatchCount == 0 && failCount == 0 && checkCount > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((plannedRequests * 400 + resetCycles) * clkPeriod);
    $display("timeout: the DUT stopped answering before all requests completed");
    $display("checks %0d, mismatches %0d, other errors %0d",
             checkCount, mismatchCount, failCount);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
cache_pkg.sv
memRead_if.sv
memWrite_if.sv
instCache.sv
dataCache.sv
axiReadEngine.sv
axiWriteEngine.sv
cacheTop.sv
cacheChecker.sv
tb_cacheTop.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
verilator --binary -f tb.f --top-module tb_cacheTop -o simv > build.log 2>&1 &&
  ./obj_dir/simv > sim.log 2>&1 ||
  { cat build.log; echo "build or simulation did not complete"; exit 1; }
tail -n 2 sim.log
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
